/* include/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// boot exception vector, kseg1
`define FETCH_RESET_VECTOR 32'hBFC0_0000

// datapath widths
`define FETCH_XLEN      32
`define FETCH_LINE_BITS 64

// byte steps
`define FETCH_LINE_STEP  32'd8
`define FETCH_INSTR_STEP 32'd4

// low pc bits that must be zero for an instruction fetch
`define FETCH_ALIGN_BITS 2

`endif

/* src/fetch_pkg.sv */
`include "fetch_defines.svh"

package fetch_pkg;

    // instruction bus request, valid is a level
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] addr;
    } ibus_req_t;

    // instruction bus response strobes and line
    typedef struct packed {
        logic                        addr_ok;
        logic                        data_ok;
        logic [`FETCH_LINE_BITS-1:0] data;
    } ibus_resp_t;

    // redirect strobes from the back end
    // priority exc > eret > branch
    typedef struct packed {
        logic                   exc;
        logic                   eret;
        logic                   branch;
        logic [`FETCH_XLEN-1:0] entrance;
        logic [`FETCH_XLEN-1:0] epc;
        logic [`FETCH_XLEN-1:0] target;
    } redirect_t;

    // one fetch line, seen whole or as two instruction words
    // instr[0] is the lower address
    typedef union packed {
        logic [`FETCH_LINE_BITS-1:0]  word;
        logic [1:0][`FETCH_XLEN-1:0]  instr;
    } fetch_line_u;

    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] raw_instr;
        logic                   adel;
    } fetch_slot_t;

    // slot[0] holds the older instruction
    typedef struct packed {
        fetch_slot_t [1:0] slot;
    } fetch_bundle_t;

endpackage

/* src/pc_select.sv */
`timescale 1ns/1ps

`include "fetch_defines.svh"

module pc_select (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t i_redirect,
    input  logic                 i_advance,
    input  logic                 i_wait,
    output logic [31:0]          o_pc,
    output logic                 o_redirect_now
);

    logic [31:0] pc_q;
    logic [31:0] pc_next;

    // rank 3 exc, 2 eret, 1 branch, 0 none
    logic [1:0]  fresh_rank;
    logic [31:0] fresh_pc;

    logic        pend_valid;
    logic [1:0]  pend_rank;
    logic [31:0] pend_pc;

    logic        fresh_wins;
    logic [31:0] target_pc;

    always_comb begin
        fresh_rank = 2'd0;
        fresh_pc   = i_redirect.target;
        if (i_redirect.exc) begin
            fresh_rank = 2'd3;
            fresh_pc   = i_redirect.entrance;
        end else if (i_redirect.eret) begin
            fresh_rank = 2'd2;
            fresh_pc   = i_redirect.epc;
        end else if (i_redirect.branch) begin
            fresh_rank = 2'd1;
        end
    end

    // newer strobe wins on equal or higher rank
    assign fresh_wins = (fresh_rank != 2'd0) && (!pend_valid || fresh_rank >= pend_rank);
    assign target_pc  = fresh_wins ? fresh_pc : pend_pc;

    // a request stuck on addr_ok keeps its address, so redirects wait for the accept
    assign o_redirect_now = !i_wait && ((fresh_rank != 2'd0) || pend_valid);

    always_comb begin
        if (o_redirect_now) begin
            pc_next = target_pc;
        end else if (i_advance) begin
            pc_next = pc_q + `FETCH_LINE_STEP;
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `FETCH_RESET_VECTOR;
        end else begin
            pc_q <= pc_next;
        end
    end

    // saved redirect while the bus holds us off
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            pend_rank  <= 2'd0;
        end else if (o_redirect_now) begin
            pend_valid <= 1'b0;
            pend_rank  <= 2'd0;
        end else if (i_wait && fresh_wins) begin
            pend_valid <= 1'b1;
            pend_rank  <= fresh_rank;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wait && fresh_wins) begin
            pend_pc <= fresh_pc;
        end
    end

    assign o_pc = pc_q;

    // pc holds while a request waits for addr_ok
    a_pc_hold: assert property (@(posedge clk) disable iff (reset)
        i_wait |=> $stable(pc_q));

endmodule

/* src/fetch_request.sv */
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_request (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            i_pc,
    input  logic                   i_redirect_now,
    input  logic                   i_full,
    input  fetch_pkg::ibus_resp_t  i_iresp,
    output fetch_pkg::ibus_req_t   o_ireq,
    output logic                   o_advance,
    output logic                   o_wait,
    output logic                   o_line_valid,
    output logic [31:0]            o_line_pc,
    output fetch_pkg::fetch_line_u o_line_data,
    output logic                   o_adel_valid
);

    logic        run_q;
    logic        wait_q;
    logic        out_q;
    logic        kill_q;
    logic        halt_q;
    logic        adel_q;
    logic [31:0] out_pc_q;

    logic        misaligned;
    logic        busy;
    logic        req_valid;
    logic        accept;
    logic        raise_adel;

    assign misaligned = i_pc[`FETCH_ALIGN_BITS-1:0] != '0;

    // a new request may go out in the cycle the previous line returns
    assign busy = out_q && !i_iresp.data_ok;

    // once raised, hold the request until addr_ok
    assign req_valid = run_q && !misaligned && !halt_q && (wait_q || (!i_full && !busy));
    assign accept    = req_valid && i_iresp.addr_ok;

    assign o_ireq.valid = req_valid;
    assign o_ireq.addr  = i_pc;
    assign o_advance    = accept;
    assign o_wait       = req_valid && !i_iresp.addr_ok;

    // bad pc, report once and stop
    assign raise_adel = run_q && misaligned && !halt_q && !i_full && !i_redirect_now;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q  <= 1'b0;
            wait_q <= 1'b0;
            out_q  <= 1'b0;
            kill_q <= 1'b0;
            halt_q <= 1'b0;
            adel_q <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            wait_q <= o_wait;
            adel_q <= raise_adel;
            if (accept) begin
                out_q  <= 1'b1;
                kill_q <= i_redirect_now;
            end else if (i_iresp.data_ok) begin
                out_q  <= 1'b0;
                kill_q <= 1'b0;
            end else if (i_redirect_now) begin
                kill_q <= 1'b1;
            end
            if (i_redirect_now) begin
                halt_q <= 1'b0;
            end else if (raise_adel) begin
                halt_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc_q <= i_pc;
        end
    end

    // drop lines of killed requests and lines racing a redirect
    assign o_line_valid     = i_iresp.data_ok && out_q && !kill_q && !i_redirect_now;
    // pc holds while halted, so it still names the faulting address
    assign o_line_pc        = adel_q ? i_pc : out_pc_q;
    assign o_line_data.word = i_iresp.data;
    assign o_adel_valid     = adel_q;

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        o_wait |=> o_ireq.valid && $stable(o_ireq.addr));

    a_no_orphan_data: assert property (@(posedge clk) disable iff (reset)
        i_iresp.data_ok |-> out_q);

endmodule

/* src/fetch_buffer.sv */
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_flush,
    input  logic                     i_decode_stall,
    input  logic                     i_line_valid,
    input  logic [31:0]              i_line_pc,
    input  fetch_pkg::fetch_line_u   i_line_data,
    input  logic                     i_adel_valid,
    output fetch_pkg::fetch_bundle_t o_bundle,
    output logic                     o_full
);

    import fetch_pkg::*;

    fetch_bundle_t out_q;

    // second line parked while decode stalls
    logic          hold_valid;
    logic [31:0]   hold_pc;
    fetch_line_u   hold_line;
    logic          hold_adel;

    logic          in_valid;
    logic          out_valid;
    logic          out_free;
    fetch_bundle_t in_bundle;
    fetch_bundle_t hold_bundle;

    // split one line into two slots
    // an address error gives slot 0 only, with no instruction word
    function automatic fetch_bundle_t build_bundle(
        input logic [31:0] pc,
        input fetch_line_u line,
        input logic        adel
    );
        fetch_bundle_t b;
        b.slot[0].valid     = 1'b1;
        b.slot[0].pc        = pc;
        b.slot[0].raw_instr = adel ? '0 : line.instr[0];
        b.slot[0].adel      = adel;
        b.slot[1].valid     = !adel;
        b.slot[1].pc        = pc + `FETCH_INSTR_STEP;
        b.slot[1].raw_instr = adel ? '0 : line.instr[1];
        b.slot[1].adel      = 1'b0;
        return b;
    endfunction

    assign in_valid    = i_line_valid || i_adel_valid;
    assign in_bundle   = build_bundle(i_line_pc, i_line_data, i_adel_valid);
    assign hold_bundle = build_bundle(hold_pc, hold_line, hold_adel);

    assign out_valid = out_q.slot[0].valid;

    // output takes a new bundle when empty or when decode drains it
    assign out_free = !out_valid || !i_decode_stall;

    // leave room for the line that may already be in flight
    assign o_full = hold_valid || (out_valid && i_decode_stall);

    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            out_q.slot[0].valid <= 1'b0;
            out_q.slot[1].valid <= 1'b0;
            hold_valid          <= 1'b0;
        end else if (out_free) begin
            if (hold_valid) begin
                out_q      <= hold_bundle;
                hold_valid <= in_valid;
            end else if (in_valid) begin
                out_q <= in_bundle;
            end else begin
                out_q.slot[0].valid <= 1'b0;
                out_q.slot[1].valid <= 1'b0;
            end
        end else if (in_valid) begin
            hold_valid <= 1'b1;
        end
    end

    // raw line kept whole, split again on the way out
    always_ff @(posedge clk) begin
        if (in_valid && (hold_valid || !out_free)) begin
            hold_pc        <= i_line_pc;
            hold_line.word <= i_line_data.word;
            hold_adel      <= i_adel_valid;
        end
    end

    assign o_bundle = out_q;

    // request side must never send a line with both stages occupied
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        in_valid && !i_flush |-> !(hold_valid && i_decode_stall));

endmodule

/* src/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                     clk,
    input  logic                     reset,
    input  fetch_pkg::redirect_t     i_redirect,
    input  logic                     i_decode_stall,
    input  fetch_pkg::ibus_resp_t    i_iresp,
    output fetch_pkg::ibus_req_t     o_ireq,
    output fetch_pkg::fetch_bundle_t o_bundle
);

    import fetch_pkg::*;

    logic [31:0] pc;
    logic        redirect_now;
    logic        advance;
    logic        req_wait;
    logic        line_valid;
    logic [31:0] line_pc;
    fetch_line_u line_data;
    logic        adel_valid;
    logic        full;

    pc_select u_pc_select (
        .clk            (clk),
        .reset          (reset),
        .i_redirect     (i_redirect),
        .i_advance      (advance),
        .i_wait         (req_wait),
        .o_pc           (pc),
        .o_redirect_now (redirect_now)
    );

    fetch_request u_fetch_request (
        .clk            (clk),
        .reset          (reset),
        .i_pc           (pc),
        .i_redirect_now (redirect_now),
        .i_full         (full),
        .i_iresp        (i_iresp),
        .o_ireq         (o_ireq),
        .o_advance      (advance),
        .o_wait         (req_wait),
        .o_line_valid   (line_valid),
        .o_line_pc      (line_pc),
        .o_line_data    (line_data),
        .o_adel_valid   (adel_valid)
    );

    // flush on the same edge that loads the redirect pc
    fetch_buffer u_fetch_buffer (
        .clk            (clk),
        .reset          (reset),
        .i_flush        (redirect_now),
        .i_decode_stall (i_decode_stall),
        .i_line_valid   (line_valid),
        .i_line_pc      (line_pc),
        .i_line_data    (line_data),
        .i_adel_valid   (adel_valid),
        .o_bundle       (o_bundle),
        .o_full         (full)
    );

endmodule

/* testbench/fetch_checker.sv */
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  fetch_pkg::redirect_t     i_redirect,
    input  logic                     i_decode_stall,
    input  fetch_pkg::ibus_resp_t    i_iresp,
    input  fetch_pkg::ibus_req_t     i_ireq,
    input  fetch_pkg::fetch_bundle_t i_bundle,
    output logic                     o_error,
    output logic [3:0]               o_adel_count
);

    import fetch_pkg::*;

    localparam logic [31:0] MEM_KEY = 32'h1234_5678;
    localparam logic [7:0]  IDLE_LIMIT = 8'd100;

    logic [31:0] exp_pc;
    logic        pend_valid;
    logic [1:0]  pend_rank;
    logic [31:0] pend_pc;
    logic [1:0]  fresh_rank;
    logic [31:0] fresh_pc;
    logic        fresh_wins;
    logic        bus_wait;
    logic        apply;
    logic        accept;
    logic        consume;
    logic        is_adel;

    // accepted addresses still owed to decode in order
    logic [31:0] acc_fifo [0:15];
    logic [3:0]  wr_ptr;
    logic [3:0]  rd_ptr;
    logic [31:0] head_pc;
    logic [3:0]  adel_count;
    logic [7:0]  idle_count;

    initial o_error = 1'b0;

    task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        o_error = 1'b1;
    endtask

    // priority exc over eret over branch
    always_comb begin
        fresh_rank = 2'd0;
        fresh_pc   = i_redirect.target;
        if (i_redirect.exc) begin
            fresh_rank = 2'd3;
            fresh_pc   = i_redirect.entrance;
        end else if (i_redirect.eret) begin
            fresh_rank = 2'd2;
            fresh_pc   = i_redirect.epc;
        end else if (i_redirect.branch) begin
            fresh_rank = 2'd1;
        end
    end

    assign bus_wait   = i_ireq.valid && !i_iresp.addr_ok;
    assign accept     = i_ireq.valid && i_iresp.addr_ok;
    assign fresh_wins = (fresh_rank != 2'd0) && (!pend_valid || fresh_rank >= pend_rank);
    assign apply      = !bus_wait && ((fresh_rank != 2'd0) || pend_valid);
    assign is_adel    = i_bundle.slot[0].adel;
    assign consume    = i_bundle.slot[0].valid && !i_decode_stall;
    assign head_pc    = acc_fifo[rd_ptr];
    assign o_adel_count = adel_count;

    always @(posedge clk) begin
        if (reset) begin
            exp_pc     <= `FETCH_RESET_VECTOR;
            pend_valid <= 1'b0;
            pend_rank  <= 2'd0;
            wr_ptr     <= 4'd0;
            rd_ptr     <= 4'd0;
            adel_count <= 4'd0;
        end else begin
            if (apply) begin
                exp_pc     <= fresh_wins ? fresh_pc : pend_pc;
                pend_valid <= 1'b0;
                pend_rank  <= 2'd0;
            end else if (accept) begin
                exp_pc <= exp_pc + `FETCH_LINE_STEP;
            end
            if (bus_wait && fresh_wins) begin
                pend_valid <= 1'b1;
                pend_rank  <= fresh_rank;
                pend_pc    <= fresh_pc;
            end
            // a redirect kills everything accepted so far including this cycle's accept
            if (apply) begin
                rd_ptr <= wr_ptr;
            end else begin
                if (accept) begin
                    acc_fifo[wr_ptr] <= i_ireq.addr;
                    wr_ptr           <= wr_ptr + 4'd1;
                end
                if (consume && !is_adel) begin
                    rd_ptr <= rd_ptr + 4'd1;
                end
            end
            if (apply) begin
                adel_count <= 4'd0;
            end else if (consume && is_adel) begin
                adel_count <= adel_count + 4'd1;
            end
        end
    end

    // cycles since decode last took a bundle, zero while fetch is halted
    always @(posedge clk) begin
        if (reset || consume || exp_pc[1:0] != 2'b00) begin
            idle_count <= 8'd0;
        end else begin
            idle_count <= idle_count + 8'd1;
        end
    end

    a_req_addr: assert property (@(posedge clk) disable iff (reset)
        i_ireq.valid |-> i_ireq.addr == exp_pc)
        else report_error("request address differs from expected pc");

    a_no_misaligned_req: assert property (@(posedge clk) disable iff (reset)
        exp_pc[1:0] != 2'b00 |-> !i_ireq.valid)
        else report_error("bus request raised for a misaligned pc");

    a_slot_pair: assert property (@(posedge clk) disable iff (reset)
        i_bundle.slot[0].valid && !is_adel |->
            i_bundle.slot[1].valid && !i_bundle.slot[1].adel &&
            i_bundle.slot[1].pc == i_bundle.slot[0].pc + 32'd4)
        else report_error("slot 1 is not the valid follower of slot 0");

    a_raw_words: assert property (@(posedge clk) disable iff (reset)
        i_bundle.slot[0].valid && !is_adel |->
            i_bundle.slot[0].raw_instr == (i_bundle.slot[0].pc ^ MEM_KEY) &&
            i_bundle.slot[1].raw_instr == (i_bundle.slot[1].pc ^ MEM_KEY))
        else report_error("raw instruction word does not match memory");

    a_adel_shape: assert property (@(posedge clk) disable iff (reset)
        i_bundle.slot[0].valid && is_adel |->
            !i_bundle.slot[1].valid && i_bundle.slot[0].raw_instr == 32'd0 &&
            i_bundle.slot[0].pc[1:0] != 2'b00 && i_bundle.slot[0].pc == exp_pc)
        else report_error("address error bundle has the wrong shape");

    a_order: assert property (@(posedge clk) disable iff (reset)
        consume && !is_adel |-> wr_ptr != rd_ptr && head_pc == i_bundle.slot[0].pc)
        else report_error("bundle out of order, lost, duplicated or stale");

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        i_decode_stall && i_bundle.slot[0].valid && !apply |=> $stable(i_bundle))
        else report_error("bundle changed while decode stalled");

    a_single_adel: assert property (@(posedge clk) disable iff (reset)
        adel_count <= 4'd1)
        else report_error("more than one address error bundle");

    a_progress: assert property (@(posedge clk) disable iff (reset)
        idle_count < IDLE_LIMIT)
        else report_error("no bundle reached decode for too many cycles");

endmodule

/* testbench/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

    import fetch_pkg::*;

    localparam logic [31:0] MEM_KEY = 32'h1234_5678;
    localparam int MAX_CYCLES = 4000;

    logic          clk;
    logic          reset;
    redirect_t     redirect;
    logic          decode_stall;
    ibus_resp_t    iresp;
    ibus_req_t     ireq;
    fetch_bundle_t bundle;

    logic          chk_error;
    logic [3:0]    adel_count;
    logic          tb_error;
    logic          fail_now;
    logic          stall_on;
    logic          hold_aok;
    logic          outstanding;
    logic [31:0]   line_addr;
    int            data_delay;
    int            aok_delay;
    int            cycle_count;

    fetch_top u_fetch_top (
        .clk            (clk),
        .reset          (reset),
        .i_redirect     (redirect),
        .i_decode_stall (decode_stall),
        .i_iresp        (iresp),
        .o_ireq         (ireq),
        .o_bundle       (bundle)
    );

    fetch_checker u_fetch_checker (
        .clk            (clk),
        .reset          (reset),
        .i_redirect     (redirect),
        .i_decode_stall (decode_stall),
        .i_iresp        (iresp),
        .i_ireq         (ireq),
        .i_bundle       (bundle),
        .o_error        (chk_error),
        .o_adel_count   (adel_count)
    );

    assign fail_now = chk_error || tb_error;

    always #5 clk = ~clk;

    always @(posedge fail_now) begin
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    // memory model, one outstanding line with random latencies
    always @(posedge clk) begin
        if (reset) begin
            outstanding = 1'b0;
        end else begin
            if (iresp.data_ok) begin
                outstanding = 1'b0;
            end
            if (ireq.valid && iresp.addr_ok) begin
                outstanding = 1'b1;
                line_addr   = ireq.addr;
                data_delay  = $urandom_range(0, 3);
                aok_delay   = $urandom_range(0, 3);
            end
        end
        #1;
        if (!reset && outstanding && data_delay == 0) begin
            iresp.data_ok = 1'b1;
            iresp.data    = {(line_addr + 32'd4) ^ MEM_KEY, line_addr ^ MEM_KEY};
        end else begin
            iresp.data_ok = 1'b0;
            iresp.data    = '0;
            if (outstanding) begin
                data_delay = data_delay - 1;
            end
        end
        if (reset || hold_aok) begin
            iresp.addr_ok = 1'b0;
        end else if (aok_delay == 0) begin
            iresp.addr_ok = 1'b1;
        end else begin
            iresp.addr_ok = 1'b0;
            aok_delay     = aok_delay - 1;
        end
    end

    always @(posedge clk) begin
        #1;
        decode_stall = stall_on && ($urandom_range(0, 3) == 0);
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // one-cycle redirect strobe
    task automatic send_redirect(input logic exc, input logic eret, input logic branch,
                                 input logic [31:0] entrance, input logic [31:0] epc,
                                 input logic [31:0] target);
        @(posedge clk);
        #1;
        redirect.exc      = exc;
        redirect.eret     = eret;
        redirect.branch   = branch;
        redirect.entrance = entrance;
        redirect.epc      = epc;
        redirect.target   = target;
        @(posedge clk);
        #1;
        redirect.exc    = 1'b0;
        redirect.eret   = 1'b0;
        redirect.branch = 1'b0;
    endtask

    function automatic logic [31:0] random_line_addr(input logic [31:0] base);
        return base | ($urandom & 32'h0000_0FF8);
    endfunction

    // park a request on addr_ok low so redirects get saved
    task automatic stall_bus_until_request();
        hold_aok = 1'b1;
        wait_cycles(2);
        while (!ireq.valid) begin
            wait_cycles(1);
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        redirect     = '0;
        decode_stall = 1'b0;
        iresp        = '0;
        tb_error     = 1'b0;
        stall_on     = 1'b0;
        hold_aok     = 1'b0;
        outstanding  = 1'b0;
        line_addr    = '0;
        data_delay   = 0;
        aok_delay    = 0;
        cycle_count  = 0;
        void'($urandom(32'hccb2_a3c7));

        repeat (5) @(posedge clk);
        #1;
        reset    = 1'b0;
        stall_on = 1'b1;
        wait_cycles(300);

        // plain branches, one to a 4-byte aligned target
        repeat (20) begin
            send_redirect(1'b0, 1'b0, 1'b1, '0, '0, random_line_addr(32'h0040_0000));
            wait_cycles($urandom_range(3, 18));
        end
        send_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0040_0104);
        wait_cycles(20);

        // all three strobes together
        repeat (10) begin
            send_redirect(1'b1, 1'b1, 1'b1, 32'h8000_0180,
                          random_line_addr(32'h0041_0000), random_line_addr(32'h0042_0000));
            wait_cycles($urandom_range(5, 25));
            send_redirect(1'b0, 1'b1, 1'b1, '0,
                          random_line_addr(32'h0041_0000), random_line_addr(32'h0042_0000));
            wait_cycles($urandom_range(5, 15));
        end

        // saved branch replaced by eret, later branch must not replace it
        stall_bus_until_request();
        send_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0043_0000);
        send_redirect(1'b0, 1'b1, 1'b0, '0, 32'h0043_1000, '0);
        send_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0043_2000);
        hold_aok = 1'b0;
        wait_cycles(40);

        // saved exception, then a lower eret arrives
        stall_bus_until_request();
        send_redirect(1'b1, 1'b0, 1'b0, 32'h8000_0180, '0, '0);
        send_redirect(1'b0, 1'b1, 1'b0, '0, 32'h0043_3000, '0);
        wait_cycles(3);
        hold_aok = 1'b0;
        wait_cycles(40);

        // saved branch replaced by a later branch of equal rank
        stall_bus_until_request();
        send_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0043_4000);
        send_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0043_5000);
        hold_aok = 1'b0;
        wait_cycles(40);

        // misaligned target halts fetch with a single address error
        stall_on = 1'b0;
        wait_cycles(2);
        send_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0044_0102);
        wait_cycles(30);
        assert (adel_count == 4'd1) else begin
            $display("FAILED at %0t ns: expected one address error bundle, saw %0d",
                     $time, adel_count);
            tb_error = 1'b1;
        end
        send_redirect(1'b0, 1'b1, 1'b0, '0, 32'h0044_0200, '0);
        stall_on = 1'b1;
        wait_cycles(300);

        if (fail_now) begin
            $display("STATUS: FAIL");
            $fatal(1, "checks failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+include
src/fetch_pkg.sv
src/pc_select.sv
src/fetch_request.sv
src/fetch_buffer.sv
src/fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - include
    files:
      - src/fetch_pkg.sv
      - src/pc_select.sv
      - src/fetch_request.sv
      - src/fetch_buffer.sv
      - src/fetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/fetch_checker.sv
      - testbench/tb_fetch_top.sv
